/* Makefile */
SIM      ?= verilator
TOP      ?= tb_lsb
FILELIST ?= src.f
FLAGS    ?= --binary --timing --assert -Wno-fatal
OBJ_DIR  ?= obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/lsb_mem_model.sv */
`timescale 1ns/1ps

module lsb_mem_model (
    input  logic        clk_in,
    input  logic        req,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic        range_err
);
    logic [7:0] mem [256];
    int         a;

    // every byte differs with the address
    initial begin
        for (a = 0; a < 256; a++) begin
            mem[a] = 8'((a * 37 + 11) ^ (a >> 3));
        end
        rdata = '0;
    end

    // access outside the 256-byte window
    assign range_err = req && (addr[31:8] != '0);

    always @(posedge clk_in) begin
        if (req) begin
            if (we) begin
                mem[addr[7:0]] <= wdata;
            end else begin
                rdata <= mem[addr[7:0]];  // one cycle latency
            end
        end
    end

endmodule

/* sim/tb_lsb.sv */
`timescale 1ns/1ps

module tb_lsb;
    import lsb_pkg::*;

    logic clk_in, rst_in, disp_valid, cdb_valid, store_commit;
    op_t disp_op;
    logic [TAG_W-1:0] disp_tag, disp_rs1_tag, disp_rs2_tag, cdb_tag, ld_tag;
    logic [31:0] disp_imm, disp_rs1_val, disp_rs2_val, cdb_value, mem_addr, ld_value;
    logic mem_req, mem_we, ld_valid, credit_ret, range_err, settle;
    logic [7:0] mem_wdata, mem_rdata;

    int seed, credits, cycle, loads_dispatched, loads_returned, stores_dispatched, commits_sent;
    logic [TAG_W-1:0] next_tag, pend_tag;
    logic [31:0] pend_val;
    logic [7:0] mirror [256];
    logic [TAG_W-1:0] ld_tag_q[$];
    logic [31:0] ld_val_q[$];
    int wr_addr_q[$], wr_idx_q[$], st_loads_q[$], st_cyc_q[$], rd_addr_q[$];
    logic [7:0] wr_data_q[$];
    op_t op_list [8];

    lsb_top u_lsb_top (.*);

    lsb_mem_model u_mem (
        .clk_in, .req(mem_req), .we(mem_we), .addr(mem_addr),
        .wdata(mem_wdata), .rdata(mem_rdata), .range_err
    );

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        $display("Test failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic fail_msg(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "%s", msg);
    endtask

    function automatic logic [31:0] load_value(op_t op, int a);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < op_bytes(op); i++) w[i*8 +: 8] = mirror[a + i];
        case (op)
            OP_LB:   return {{24{w[7]}}, w[7:0]};
            OP_LH:   return {{16{w[15]}}, w[15:0]};
            default: return w;  // lw, lbu, lhu already zero above
        endcase
    endfunction

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    always @(posedge clk_in) cycle <= cycle + 1;

    // 1 ns past the next rising edge
    task automatic tick();
        @(posedge clk_in);
        #1;
        disp_valid = 1'b0;
        cdb_valid  = 1'b0;
    endtask

    task automatic broadcast(input logic [TAG_W-1:0] tag, input logic [31:0] val);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_value = val;
        tick();
    endtask

    // mode 0 ready, 1 pending rs1, 2 rs1 bypassed in the dispatch cycle
    task automatic send(input op_t op, input int target, input int mode);
        int imm;
        int t;
        logic [31:0] rs1;
        logic [31:0] data;
        logic [TAG_W-1:0] ptag;
        imm  = $random(seed) % 16;
        rs1  = target - imm;
        data = $random(seed);
        ptag = TAG_W'(1 + ($unsigned($random(seed)) % 15));
        t = 0;
        while (credits == 0) begin
            tick();
            t++;
            if (t > 300) fail_msg("no credit came back while waiting to dispatch");
        end
        disp_valid   = 1'b1;
        disp_op      = op;
        disp_tag     = next_tag;
        disp_imm     = imm;
        disp_rs2_val = data;
        disp_rs2_tag = '0;
        disp_rs1_val = (mode == 0) ? rs1 : ~rs1;  // stale value if pending
        disp_rs1_tag = (mode == 0) ? '0 : ptag;
        if (mode != 0) begin
            pend_tag = ptag;  // kept until its broadcast
            pend_val = rs1;
        end
        if (mode == 2) begin
            cdb_valid = 1'b1;
            cdb_tag   = ptag;
            cdb_value = rs1;
        end
        credits--;
        if (is_store(op)) begin
            for (int i = 0; i < op_bytes(op); i++) begin
                wr_addr_q.push_back(target + i);
                wr_data_q.push_back(data[i*8 +: 8]);
                wr_idx_q.push_back(stores_dispatched);
                mirror[target + i] = data[i*8 +: 8];
            end
            st_loads_q.push_back(loads_dispatched);
            st_cyc_q.push_back(cycle);
            stores_dispatched++;
        end else begin
            for (int i = 0; i < op_bytes(op); i++) begin
                rd_addr_q.push_back(target + i);
            end
            ld_tag_q.push_back(next_tag);
            ld_val_q.push_back(load_value(op, target));
            loads_dispatched++;
        end
        next_tag = (next_tag == 15) ? 1 : next_tag + 1;
        tick();
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (credits != LSB_DEPTH || ld_tag_q.size() != 0 || wr_addr_q.size() != 0) begin
            tick();
            t++;
            if (t > 2000) fail_msg("buffer did not drain");
        end
    endtask

    // rob model commits a store once every older load returned
    initial begin
        store_commit = 1'b0;
        forever begin
            @(posedge clk_in);
            #1;
            store_commit = 1'b0;
            if (!rst_in && st_loads_q.size() != 0 && st_loads_q[0] <= loads_returned
                && cycle >= st_cyc_q[0] + 2) begin
                store_commit = 1'b1;
                void'(st_loads_q.pop_front());
                void'(st_cyc_q.pop_front());
                commits_sent++;
            end
        end
    end

    always @(negedge clk_in) begin
        if (!rst_in) begin
            if (credit_ret) credits++;
            if (ld_valid) begin
                assert (ld_tag_q.size() != 0)
                    else fail_msg("load result with no load outstanding");
                assert (ld_tag == ld_tag_q[0])
                    else fail_value("ld_tag", 32'(ld_tag), 32'(ld_tag_q[0]));
                assert (ld_value == ld_val_q[0])
                    else fail_value("ld_value", ld_value, ld_val_q[0]);
                void'(ld_tag_q.pop_front());
                void'(ld_val_q.pop_front());
                loads_returned++;
            end
            if (mem_req && !mem_we) begin
                assert (rd_addr_q.size() != 0)
                    else fail_msg("memory read with no load pending");
                assert (mem_addr == 32'(rd_addr_q[0]))
                    else fail_value("mem_addr", mem_addr, rd_addr_q[0]);
                void'(rd_addr_q.pop_front());
            end
            if (mem_req && mem_we) begin
                assert (wr_addr_q.size() != 0)
                    else fail_msg("memory write with no store pending");
                assert (wr_idx_q[0] < commits_sent)
                    else fail_msg("store written before its commit");
                assert (mem_addr == 32'(wr_addr_q[0]))
                    else fail_value("mem_addr", mem_addr, wr_addr_q[0]);
                assert (mem_wdata == wr_data_q[0])
                    else fail_value("mem_wdata", 32'(mem_wdata), 32'(wr_data_q[0]));
                void'(wr_addr_q.pop_front());
                void'(wr_data_q.pop_front());
                void'(wr_idx_q.pop_front());
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk_in)
        settle |-> (!mem_req && !mem_we && !ld_valid && !credit_ret))
        else fail_msg("memory or result activity right after reset");
    a_credit_range: assert property (@(posedge clk_in) credits >= 0 && credits <= LSB_DEPTH)
        else fail_value("credits", credits, LSB_DEPTH);
    a_in_window: assert property (@(posedge clk_in) disable iff (rst_in) !range_err)
        else fail_msg("memory access outside the 256-byte window");
    a_load_timing: assert property (@(posedge clk_in) disable iff (rst_in)
        ld_valid |-> ($past(mem_req && !mem_we, 2) && !$past(mem_req && !mem_we, 1)))
        else fail_msg("ld_valid not two cycles after the last read request");

    initial begin
        #3_000_000;
        fail_msg("simulation watchdog expired");
    end

    initial begin
        int r;
        int mode;
        int target;
        int last_st;
        op_t op;
        seed = 97678;
        {disp_valid, cdb_valid, settle} = '0;
        {disp_tag, disp_rs1_tag, disp_rs2_tag, cdb_tag} = '0;
        {disp_imm, disp_rs1_val, disp_rs2_val, cdb_value} = '0;
        disp_op = OP_LB;
        {loads_dispatched, loads_returned, stores_dispatched, commits_sent} = '0;
        credits  = LSB_DEPTH;
        next_tag = 1;
        last_st  = -1;
        op_list  = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
        for (int a = 0; a < 256; a++) mirror[a] = 8'((a * 37 + 11) ^ (a >> 3));
        rst_in = 1'b1;
        repeat (2) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        settle = 1'b1;
        repeat (3) tick();
        settle = 1'b0;
        // head waits on a tag while the rest fill the buffer
        send(OP_LW, 16, 1);
        for (int n = 1; n < LSB_DEPTH; n++) begin
            op = op_list[$unsigned($random(seed)) % 5];
            send(op, $unsigned($random(seed)) % (257 - op_bytes(op)), 0);
        end
        assert (credits == 0) else fail_value("credits", credits, 0);
        repeat (3) tick();
        broadcast(pend_tag, pend_val);
        drain();
        for (int n = 0; n < 200; n++) begin
            r      = $unsigned($random(seed)) % 8;
            op     = op_list[r];
            mode   = $unsigned($random(seed)) % 3;
            target = $unsigned($random(seed)) % (257 - op_bytes(op));
            if (is_store(op)) begin
                if (mode == 1) mode = 0;  // stores keep ready operands
                last_st = target;
            end else if (last_st >= 0 && $random(seed) % 2 == 0) begin
                target = (last_st > 256 - op_bytes(op)) ? 256 - op_bytes(op) : last_st;
            end
            send(op, target, mode);
            if (mode == 1) begin
                repeat ($unsigned($random(seed)) % 4) tick();
                broadcast(pend_tag, pend_val);
            end
        end
        drain();
        $display("Test passed");
        $finish;
    end

endmodule

/* src.f */
src/lsb_pkg.sv
src/lsb_slot_if.sv
src/lsb_alloc.sv
src/lsb_slot.sv
src/lsb_mem_seq.sv
src/lsb_top.sv
sim/lsb_mem_model.sv
sim/tb_lsb.sv

/* src/lsb_alloc.sv */
`timescale 1ns/1ps

module lsb_alloc (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      disp_valid,
    input  lsb_pkg::op_t              disp_op,
    input  logic [lsb_pkg::TAG_W-1:0] disp_tag,
    input  logic [lsb_pkg::IMM_W-1:0] disp_imm,
    input  logic [lsb_pkg::XLEN-1:0]  disp_rs1_val,
    input  logic [lsb_pkg::TAG_W-1:0] disp_rs1_tag,
    input  logic [lsb_pkg::XLEN-1:0]  disp_rs2_val,
    input  logic [lsb_pkg::TAG_W-1:0] disp_rs2_tag,
    input  logic                      cdb_valid,
    input  logic [lsb_pkg::TAG_W-1:0] cdb_tag,
    input  logic [lsb_pkg::XLEN-1:0]  cdb_value,
    lsb_slot_if.alloc                 slots [lsb_pkg::LSB_DEPTH]
);
    import lsb_pkg::*;

    logic [PTR_W-1:0]     tail;
    logic                 rs1_hit;
    logic                 rs2_hit;
    entry_t               new_entry;
    logic [LSB_DEPTH-1:0] slot_empty;

    // broadcast in the dispatch cycle itself
    assign rs1_hit = cdb_valid && (disp_rs1_tag != '0) && (disp_rs1_tag == cdb_tag);
    assign rs2_hit = cdb_valid && (disp_rs2_tag != '0) && (disp_rs2_tag == cdb_tag);

    always_comb begin
        new_entry.op      = disp_op;
        new_entry.tag     = disp_tag;
        new_entry.imm     = disp_imm;
        new_entry.rs1_val = rs1_hit ? cdb_value : disp_rs1_val;
        new_entry.rs1_tag = rs1_hit ? '0 : disp_rs1_tag;
        new_entry.rs2_val = rs2_hit ? cdb_value : disp_rs2_val;
        new_entry.rs2_tag = rs2_hit ? '0 : disp_rs2_tag;
    end

    genvar i;
    generate
        for (i = 0; i < LSB_DEPTH; i++) begin : g_wr
            assign slots[i].wr_en    = disp_valid && (tail == PTR_W'(i));
            assign slots[i].wr_entry = new_entry;
            assign slot_empty[i]     = (slots[i].state == SLOT_EMPTY);
        end
    endgenerate

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            tail <= '0;
        end else if (disp_valid) begin
            tail <= tail + 1'b1;  // wraps at depth
        end
    end

    // credits must keep the dispatcher off occupied slots
    a_no_overflow: assert property (
        @(posedge clk_in) disable iff (rst_in)
        disp_valid |-> slot_empty[tail]
    ) else $error("dispatch into occupied slot %0d", tail);

endmodule

/* src/lsb_mem_seq.sv */
`timescale 1ns/1ps

module lsb_mem_seq (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      store_commit,
    lsb_slot_if.seq                   slots [lsb_pkg::LSB_DEPTH],
    output logic                      mem_req,
    output logic                      mem_we,
    output logic [lsb_pkg::XLEN-1:0]  mem_addr,
    output logic [7:0]                mem_wdata,
    input  logic [7:0]                mem_rdata,
    output logic                      ld_valid,
    output logic [lsb_pkg::TAG_W-1:0] ld_tag,
    output logic [lsb_pkg::XLEN-1:0]  ld_value,
    output logic                      credit_ret
);
    import lsb_pkg::*;

    slot_state_t      state_v [LSB_DEPTH];
    entry_t           ent_v   [LSB_DEPTH];
    slot_state_t      head_state;
    entry_t           head_ent;

    logic [PTR_W-1:0] head;
    logic [PTR_W:0]   commit_cnt;  // committed stores from head on
    logic [PTR_W-1:0] commit_idx;

    logic             busy;
    logic             cur_store;
    op_t              cur_op;
    logic [TAG_W-1:0] cur_tag;
    logic [2:0]       req_left;    // requests after the current one
    logic [2:0]       pend_cnt;    // read bytes not yet back
    logic             rd_valid;    // mem_rdata carries a byte
    logic [1:0]       byte_idx;
    logic [XLEN-1:0]  collect;
    logic [XLEN-1:0]  asm_word;
    logic [XLEN-1:0]  wshift;      // store bytes still to write

    logic             start;
    logic             fin_load;
    logic             fin_store;
    logic             do_free;

    function automatic logic [XLEN-1:0] extend(op_t op, logic [XLEN-1:0] w);
        case (op)
            OP_LB:   return {{(XLEN-8){w[7]}}, w[7:0]};
            OP_LH:   return {{(XLEN-16){w[15]}}, w[15:0]};
            OP_LBU:  return {{(XLEN-8){1'b0}}, w[7:0]};
            OP_LHU:  return {{(XLEN-16){1'b0}}, w[15:0]};
            default: return w;
        endcase
    endfunction

    assign commit_idx = head + commit_cnt[PTR_W-1:0];

    genvar i;
    generate
        for (i = 0; i < LSB_DEPTH; i++) begin : g_port
            assign state_v[i]         = slots[i].state;
            assign ent_v[i]           = slots[i].entry;
            assign slots[i].commit_en = store_commit && (commit_idx == PTR_W'(i));
            assign slots[i].free_en   = do_free && (head == PTR_W'(i));
        end
    endgenerate

    assign head_state = state_v[head];
    assign head_ent   = ent_v[head];

    assign start = !busy && ((head_state == SLOT_READY && !is_store(head_ent.op))
                             || head_state == SLOT_COMMIT);
    assign fin_store = busy && cur_store && mem_req && (req_left == '0);
    assign fin_load  = rd_valid && (pend_cnt == 3'd1);
    assign do_free   = fin_load || fin_store;

    assign byte_idx = 2'(op_bytes(cur_op) - pend_cnt);

    always_comb begin
        asm_word = collect;
        asm_word[byte_idx*8 +: 8] = mem_rdata;  // little endian
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head       <= '0;
            commit_cnt <= '0;
            busy       <= 1'b0;
            mem_req    <= 1'b0;
            mem_we     <= 1'b0;
            rd_valid   <= 1'b0;
            req_left   <= '0;
            pend_cnt   <= '0;
            ld_valid   <= 1'b0;
            credit_ret <= 1'b0;
        end else begin
            ld_valid   <= 1'b0;
            credit_ret <= 1'b0;
            rd_valid   <= mem_req && !mem_we;
            commit_cnt <= commit_cnt + {{PTR_W{1'b0}}, store_commit}
                                     - {{PTR_W{1'b0}}, fin_store};
            if (start) begin
                busy     <= 1'b1;
                mem_req  <= 1'b1;
                mem_we   <= is_store(head_ent.op);
                req_left <= op_bytes(head_ent.op) - 3'd1;
                pend_cnt <= is_store(head_ent.op) ? 3'd0 : op_bytes(head_ent.op);
            end else if (mem_req) begin
                if (req_left != '0) begin
                    req_left <= req_left - 3'd1;
                end else begin
                    mem_req <= 1'b0;
                    mem_we  <= 1'b0;
                end
            end
            if (rd_valid) begin
                pend_cnt <= pend_cnt - 3'd1;
            end
            if (do_free) begin
                busy       <= 1'b0;
                head       <= head + 1'b1;
                credit_ret <= 1'b1;
                ld_valid   <= fin_load;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (start) begin
            cur_store <= is_store(head_ent.op);
            cur_op    <= head_ent.op;
            cur_tag   <= head_ent.tag;
            mem_addr  <= head_ent.rs1_val + head_ent.imm;
            mem_wdata <= head_ent.rs2_val[7:0];
            wshift    <= head_ent.rs2_val >> 8;
        end else if (mem_req && req_left != '0) begin
            mem_addr  <= mem_addr + 1'b1;
            mem_wdata <= wshift[7:0];
            wshift    <= wshift >> 8;
        end
        if (rd_valid) begin
            collect <= asm_word;
        end
        if (fin_load) begin
            ld_tag   <= cur_tag;
            ld_value <= extend(cur_op, asm_word);
        end
    end

    a_commit_target: assert property (
        @(posedge clk_in) disable iff (rst_in)
        store_commit |-> (state_v[commit_idx] == SLOT_READY)
    ) else $error("store commit without an uncommitted store at %0d", commit_idx);

    // last byte cycle must be quiet on the bus
    a_no_req_at_finish: assert property (
        @(posedge clk_in) disable iff (rst_in)
        fin_load |-> !mem_req
    ) else $error("request issued while finishing a load");

endmodule

/* src/lsb_pkg.sv */
package lsb_pkg;

    localparam int LSB_DEPTH = 16;
    localparam int PTR_W     = 4;
    localparam int TAG_W     = 4;   // tag 0 = no dependency
    localparam int XLEN      = 32;
    localparam int IMM_W     = 32;  // sign-extended by decoder

    // low bits follow funct3, bit 3 marks a store
    typedef enum logic [3:0] {
        OP_LB  = 4'h0,
        OP_LH  = 4'h1,
        OP_LW  = 4'h2,
        OP_LBU = 4'h4,
        OP_LHU = 4'h5,
        OP_SB  = 4'h8,
        OP_SH  = 4'h9,
        OP_SW  = 4'ha
    } op_t;

    typedef enum logic [1:0] {
        SLOT_EMPTY  = 2'd0,
        SLOT_WAIT   = 2'd1,  // operand still pending
        SLOT_READY  = 2'd2,
        SLOT_COMMIT = 2'd3   // store released by rob
    } slot_state_t;

    typedef struct packed {
        op_t              op;
        logic [TAG_W-1:0] tag;
        logic [IMM_W-1:0] imm;
        logic [XLEN-1:0]  rs1_val;
        logic [TAG_W-1:0] rs1_tag;
        logic [XLEN-1:0]  rs2_val;
        logic [TAG_W-1:0] rs2_tag;
    } entry_t;

    function automatic logic is_store(op_t op);
        return op[3];
    endfunction

    function automatic logic [2:0] op_bytes(op_t op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 3'd1;
            OP_LH, OP_LHU, OP_SH: return 3'd2;
            default:              return 3'd4;
        endcase
    endfunction

endpackage

/* src/lsb_slot.sv */
`timescale 1ns/1ps

module lsb_slot (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      cdb_valid,
    input  logic [lsb_pkg::TAG_W-1:0] cdb_tag,
    input  logic [lsb_pkg::XLEN-1:0]  cdb_value,
    lsb_slot_if.slot                  port
);
    import lsb_pkg::*;

    slot_state_t      state;
    entry_t           ent;
    logic             rs1_hit;
    logic             rs2_hit;
    logic [TAG_W-1:0] rs1_tag_nxt;
    logic [TAG_W-1:0] rs2_tag_nxt;

    assign port.state = state;
    assign port.entry = ent;

    assign rs1_hit = cdb_valid && (ent.rs1_tag != '0) && (ent.rs1_tag == cdb_tag);
    assign rs2_hit = cdb_valid && (ent.rs2_tag != '0) && (ent.rs2_tag == cdb_tag);

    assign rs1_tag_nxt = rs1_hit ? '0 : ent.rs1_tag;
    assign rs2_tag_nxt = rs2_hit ? '0 : ent.rs2_tag;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= SLOT_EMPTY;
        end else if (port.free_en) begin
            state <= SLOT_EMPTY;
        end else if (port.wr_en) begin
            if (port.wr_entry.rs1_tag == '0 && port.wr_entry.rs2_tag == '0) begin
                state <= SLOT_READY;
            end else begin
                state <= SLOT_WAIT;
            end
        end else begin
            case (state)
                SLOT_WAIT: begin
                    if (rs1_tag_nxt == '0 && rs2_tag_nxt == '0) begin
                        state <= SLOT_READY;  // last operand arrived
                    end
                end
                SLOT_READY: begin
                    if (port.commit_en) begin
                        state <= SLOT_COMMIT;
                    end
                end
                default: ;
            endcase
        end
    end

    // operand capture
    always_ff @(posedge clk_in) begin
        if (port.wr_en) begin
            ent <= port.wr_entry;
        end else if (state == SLOT_WAIT) begin
            if (rs1_hit) begin
                ent.rs1_val <= cdb_value;
                ent.rs1_tag <= '0;
            end
            if (rs2_hit) begin
                ent.rs2_val <= cdb_value;
                ent.rs2_tag <= '0;
            end
        end
    end

    a_commit_store: assert property (
        @(posedge clk_in) disable iff (rst_in)
        port.commit_en |-> is_store(ent.op)
    ) else $error("store commit hit a load");

    a_free_live: assert property (
        @(posedge clk_in) disable iff (rst_in)
        port.free_en |-> (state != SLOT_EMPTY)
    ) else $error("free of an empty slot");

endmodule

/* src/lsb_slot_if.sv */
`timescale 1ns/1ps

interface lsb_slot_if;
    import lsb_pkg::*;

    logic        wr_en;      // dispatch write
    entry_t      wr_entry;
    slot_state_t state;
    entry_t      entry;
    logic        commit_en;  // rob released this store
    logic        free_en;    // head retired

    modport alloc (
        output wr_en,
        output wr_entry,
        input  state
    );

    modport slot (
        input  wr_en,
        input  wr_entry,
        input  commit_en,
        input  free_en,
        output state,
        output entry
    );

    modport seq (
        output commit_en,
        output free_en,
        input  state,
        input  entry
    );

endinterface

/* src/lsb_top.sv */
`timescale 1ns/1ps

module lsb_top (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      disp_valid,
    input  lsb_pkg::op_t              disp_op,
    input  logic [lsb_pkg::TAG_W-1:0] disp_tag,
    input  logic [lsb_pkg::IMM_W-1:0] disp_imm,
    input  logic [lsb_pkg::XLEN-1:0]  disp_rs1_val,
    input  logic [lsb_pkg::TAG_W-1:0] disp_rs1_tag,
    input  logic [lsb_pkg::XLEN-1:0]  disp_rs2_val,
    input  logic [lsb_pkg::TAG_W-1:0] disp_rs2_tag,
    input  logic                      cdb_valid,
    input  logic [lsb_pkg::TAG_W-1:0] cdb_tag,
    input  logic [lsb_pkg::XLEN-1:0]  cdb_value,
    input  logic                      store_commit,
    output logic                      mem_req,
    output logic                      mem_we,
    output logic [lsb_pkg::XLEN-1:0]  mem_addr,
    output logic [7:0]                mem_wdata,
    input  logic [7:0]                mem_rdata,
    output logic                      ld_valid,
    output logic [lsb_pkg::TAG_W-1:0] ld_tag,
    output logic [lsb_pkg::XLEN-1:0]  ld_value,
    output logic                      credit_ret
);
    import lsb_pkg::*;

    lsb_slot_if slot_if [LSB_DEPTH] ();

    lsb_alloc u_alloc (
        .clk_in, .rst_in,
        .disp_valid, .disp_op, .disp_tag, .disp_imm,
        .disp_rs1_val, .disp_rs1_tag, .disp_rs2_val, .disp_rs2_tag,
        .cdb_valid, .cdb_tag, .cdb_value,
        .slots (slot_if)
    );

    genvar i;
    generate
        for (i = 0; i < LSB_DEPTH; i++) begin : g_slot
            lsb_slot u_slot (
                .clk_in, .rst_in,
                .cdb_valid, .cdb_tag, .cdb_value,
                .port (slot_if[i])
            );
        end
    endgenerate

    lsb_mem_seq u_seq (
        .clk_in, .rst_in,
        .store_commit,
        .slots (slot_if),
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata,
        .ld_valid, .ld_tag, .ld_value, .credit_ret
    );

endmodule
